// ==== verilog.f ====
rtl/scope_pkg.sv
rtl/sample_frontend.sv
rtl/trigger_ctrl.sv
rtl/capture_ram.sv
rtl/command_engine.sv
rtl/scope_top.sv
testbench/tb_scope.sv

// ==== testbench/scope_input.txt ====
# C: eight command bytes in hex, byte 0 first   S: four lane values in decimal, lane 0 first
# E: expected response word in hex   W: idle cycles
W 2
# settings and info
C 09 00 00 01 00 00 00 00  E 00000009
C 08 80 00 00 00 00 00 00  E 00000008
C 02 00 00 00 00 00 00 00  E 00000013
# forced capture, length 3, read 4 words
C 01 00 00 00 03 00 00 00  E 00000000
W 3
S 100 -2048 2047 -1
S 0 1 -1 500
S 1000 -1000 2000 -2000
S 7 8 9 10
C 00 00 00 00 04 00 00 00
E 07ff0f9c E 00010801
E 0fff0000 E 0e0c0001
E 03e80c18 E 07d00830
E 0ff80ff9 E 0ff60ff7
W 12
# factor 2 with highres
C 09 00 01 02 00 00 00 00  E 00000009
C 01 00 00 00 01 00 00 00  E 00000000
W 3
S 10 20 -5 -6
S 100 101 -2048 -2048
S 0 3 1 1
S -7 -8 2047 -2047
C 00 00 00 00 02 00 00 00
E 00050ff1 E 07ff0f9b
E 0fff0ffe E 00000007
W 8
# factor 2 decimation
C 09 00 00 02 00 00 00 00  E 00000009
C 01 00 00 00 01 00 00 00  E 00000000
W 3
S 10 20 -5 -6
S 100 101 -2048 -2048
S 0 3 1 1
S -7 -8 2047 -2047
C 00 00 00 00 02 00 00 00
E 00050ff6 E 07ff0f9c
E 0fff0000 E 08010007
W 8
# rising trigger, lower 8, upper 520, tot 1, preoffset 2
C 09 00 00 01 00 00 00 00  E 00000009
C 08 90 10 00 02 01 00 00  E 00000008
C 01 01 00 00 02 00 00 00  E 00000000
W 3
S 50 60 70 80
S -600 0 0 0
S -1000 -10 -20 -30
S 1 2 3 4
S -1 -2 -3 -4
C 00 00 00 00 05 00 00 00
E 0fc40fce E 0fb00fba
E 00000258 E 00000000
E 000a03e8 E 001e0014
E 0ffe0fff E 0ffc0ffd
E 00020001 E 00040003
W 14
# falling trigger, tot 0, preoffset 1, rearm while done, event count
C 08 90 10 00 01 00 00 00  E 00000008
C 01 02 00 00 01 00 00 00  E 00000000
W 3
S -700 -600 -550 -530
S 10 20 30 40
S 0 0 0 0
C 01 02 00 00 01 00 00 00  E 000000fb
C 00 00 00 00 03 00 00 00
E 025802bc E 02120226
E 0fec0ff6 E 0fd80fe2
E 00000000 E 00000000
W 10
C 02 01 00 00 00 00 00 00  E 00000005

// ==== testbench/tb_scope.sv ====
// testbench for the scope acquisition core
// replays command, sample and idle records from the stimulus file and
// checks every response word in order against the expected records
`timescale 1ns/1ps
`default_nettype none

module tb_scope;
	import scope_pkg::*;

	logic         clk;
	logic         rstn;
	logic         cmd_stb;
	logic [7:0]   cmd_byte;
	logic         adc_stb;
	sample_word_t adc_word;
	logic         rsp_stb;
	logic [31:0]  rsp_data;

	logic [7:0]   rec_kind[$];     // C, S, E or W
	logic [63:0]  rec_val[$];      // frame, sample word, response or cycle count
	logic [31:0]  exp_q[$];        // responses still owed by the DUT
	logic [31:0]  want;
	logic         opened;

	int           seed;
	int           cycles;
	int           limit;
	int           n_wrong;
	int           n_missing;
	int           n_surplus;
	int           n_bad;

	scope_top dut0 (
		.clk        (clk),
		.rstn       (rstn),
		.i_cmd_stb  (cmd_stb),
		.i_cmd_byte (cmd_byte),
		.i_adc_stb  (adc_stb),
		.i_adc_word (adc_word),
		.o_rsp_stb  (rsp_stb),
		.o_rsp_data (rsp_data)
	);

	always #4 clk = ~clk;          // 8 ns period

	// --------------------
	// stimulus file, parsed once before the run
	task automatic load_records(output logic ok);
		int          fd;
		int          code;
		int          v;
		logic [7:0]  kind;
		logic [63:0] val;
		logic [1023:0] line;
		fd = $fopen("testbench/scope_input.txt", "r");
		ok = (fd != 0);
		if (!ok) begin
			$display("cannot open the stimulus file testbench/scope_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				break;
			val = '0;
			case (kind)
				"#": code = $fgets(line, fd);   // comment, drop rest of line
				"C": begin
					for (int i = 0; i < 8; i++) begin
						code = $fscanf(fd, "%h", v);
						val[8*i +: 8] = v[7:0];     // byte 0 is the opcode
					end
				end
				"S": begin
					for (int i = 0; i < LANES; i++) begin
						code = $fscanf(fd, "%d", v);
						val[SAMPLE_W*i +: SAMPLE_W] = v[SAMPLE_W-1:0];
					end
				end
				"E": begin
					code = $fscanf(fd, "%h", v);
					val[31:0] = v;
				end
				"W": begin
					code = $fscanf(fd, "%d", v);
					val[31:0] = v;
				end
				default: begin
					$display("stimulus file holds an unknown record type '%c'", kind);
					n_bad++;
					break;
				end
			endcase
			if (kind != "#") begin
				rec_kind.push_back(kind);
				rec_val.push_back(val);
			end
		end
		$fclose(fd);
	endtask

	// --------------------
	// drivers, all on the falling edge
	task automatic idle_cycle();
		@(negedge clk);
		cmd_stb = 1'b0;
		adc_stb = 1'b0;
	endtask

	task automatic send_command(input logic [63:0] frame);
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			adc_stb  = 1'b0;
			cmd_stb  = 1'b1;
			cmd_byte = frame[8*i +: 8];    // next driver drops the strobe
		end
	endtask

	task automatic send_sample(input sample_word_t word);
		int gap;
		@(negedge clk);
		cmd_stb  = 1'b0;
		adc_stb  = 1'b1;
		adc_word = word;
		gap = $random(seed) & 3;         // 0..3 idle cycles
		repeat (gap) idle_cycle();
	endtask

	task automatic report_counts();
		$display("error counts: wrong value %0d, missing %0d, surplus %0d, bad record %0d",
		         n_wrong, n_missing, n_surplus, n_bad);
	endtask

	// --------------------
	// response monitor, sampled mid cycle
	always @(negedge clk) begin
		if (rstn && rsp_stb) begin
			assert (exp_q.size() > 0) else begin
				n_surplus++;
				$display("response %h at %0t ns arrived with no expected word left",
				         rsp_data, $time);
			end
			if (exp_q.size() > 0) begin
				want = exp_q.pop_front();
				assert (rsp_data === want) else begin
					n_wrong++;
					$display("Fail %0t ns: response %h, expected %h", $time, rsp_data, want);
				end
			end
		end
	end

	// run limit from the record count
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= limit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			report_counts();
			$display("tests failed");
			$finish;
		end
	end

	// --------------------
	initial begin
		clk       = 1'b0;
		rstn      = 1'b0;
		cmd_stb   = 1'b0;
		cmd_byte  = '0;
		adc_stb   = 1'b0;
		adc_word  = '0;
		seed      = 32'hf4a2_5622;
		cycles    = 0;
		n_wrong   = 0;
		n_missing = 0;
		n_surplus = 0;
		n_bad     = 0;
		load_records(opened);
		if (!opened)
			n_bad++;
		limit = 4 * rec_kind.size() + 200;

		repeat (8) @(posedge clk);       // reset over 8 cycles
		@(negedge clk);
		rstn = 1'b1;

		for (int k = 0; k < rec_kind.size(); k++) begin
			case (rec_kind[k])
				"C": send_command(rec_val[k]);
				"S": send_sample(rec_val[k][47:0]);
				"E": exp_q.push_back(rec_val[k][31:0]);   // response follows its command
				"W": repeat (int'(rec_val[k][31:0])) idle_cycle();
				default: ;
			endcase
		end
		repeat (16) idle_cycle();        // let the last answers drain

		assert (exp_q.size() == 0) else begin
			n_missing = exp_q.size();
			$display("%0d expected response words never arrived", n_missing);
		end
		report_counts();
		if (n_wrong + n_missing + n_surplus + n_bad == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/scope_top.sv ====
// oscilloscope acquisition core top level
// front end, trigger FSM, capture ram and command engine in one clock domain
`timescale 1ns/1ps
`default_nettype none

module scope_top (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_cmd_stb,
	input  wire [7:0]                    i_cmd_byte,
	input  wire                          i_adc_stb,
	input  wire scope_pkg::sample_word_t i_adc_word,
	output logic                         o_rsp_stb,
	output logic [scope_pkg::RSP_W-1:0]  o_rsp_data
);
	import scope_pkg::*;

	logic         merged_stb;
	sample_word_t merged_word;
	merge_cfg_t   merge_cfg;
	acq_cfg_t     acq_cfg;
	logic         arm_stb;
	logic         readout_done_stb;
	logic         wr_en;
	logic         trig_mark;
	acq_state_e   acq_state;
	logic [31:0]  event_count;
	addr_t        trig_addr;
	addr_t        rd_addr;
	sample_word_t rd_data;
	acq_status_t  status;

	// status comes from two blocks
	assign status = '{state: acq_state, trig_addr: trig_addr, event_count: event_count};

	sample_frontend u_frontend (
		.clk           (clk),
		.rstn          (rstn),
		.i_adc_stb     (i_adc_stb),
		.i_adc_word    (i_adc_word),
		.i_merge_cfg   (merge_cfg),
		.o_merged_stb  (merged_stb),
		.o_merged_word (merged_word)
	);

	trigger_ctrl u_trigger (
		.clk                (clk),
		.rstn               (rstn),
		.i_merged_stb       (merged_stb),
		.i_merged_word      (merged_word),
		.i_acq_cfg          (acq_cfg),
		.i_arm_stb          (arm_stb),
		.i_readout_done_stb (readout_done_stb),
		.o_wr_en            (wr_en),
		.o_trig_mark        (trig_mark),
		.o_state            (acq_state),
		.o_event_count      (event_count)
	);

	capture_ram #(
		.DEPTH (RAM_DEPTH)
	) u_ram (
		.clk         (clk),
		.rstn        (rstn),
		.i_wr_stb    (wr_en),
		.i_wr_word   (merged_word),
		.i_trig_mark (trig_mark),
		.i_rd_addr   (rd_addr),
		.o_rd_data   (rd_data),
		.o_trig_addr (trig_addr)
	);

	command_engine u_cmd (
		.clk                (clk),
		.rstn               (rstn),
		.i_cmd_stb          (i_cmd_stb),
		.i_cmd_byte         (i_cmd_byte),
		.i_status           (status),
		.i_rd_data          (rd_data),
		.o_acq_cfg          (acq_cfg),
		.o_merge_cfg        (merge_cfg),
		.o_arm_stb          (arm_stb),
		.o_readout_done_stb (readout_done_stb),
		.o_rd_addr          (rd_addr),
		.o_rsp_stb          (o_rsp_stb),
		.o_rsp_data         (o_rsp_data)
	);

endmodule

`default_nettype wire

// ==== rtl/command_engine.sv ====
// command and readout engine
// collects 8-byte frames, keeps the config, answers with 32-bit words
// and streams capture data from the trigger point minus the preoffset
`timescale 1ns/1ps
`default_nettype none

module command_engine (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_cmd_stb,
	input  wire [7:0]                    i_cmd_byte,
	input  wire scope_pkg::acq_status_t  i_status,
	input  wire scope_pkg::sample_word_t i_rd_data,
	output scope_pkg::acq_cfg_t          o_acq_cfg,
	output scope_pkg::merge_cfg_t        o_merge_cfg,
	output logic                         o_arm_stb,
	output logic                         o_readout_done_stb,
	output scope_pkg::addr_t             o_rd_addr,
	output logic                         o_rsp_stb,
	output logic [scope_pkg::RSP_W-1:0]  o_rsp_data
);
	import scope_pkg::*;

	cmd_frame_u          frame_q;     // byte 0 ends at the bottom
	logic [2:0]          byte_cnt;
	logic                byte_ok;     // byte accepted, none during readout
	logic                frame_vld;   // frame complete, decode now
	addr_t               preoffset;
	logic                rsp_stb_q;
	logic [RSP_W-1:0]    rsp_q;
	logic                rd_wait;     // first address out, data next cycle
	logic                rd_busy;
	logic                rd_half;     // low: lanes 1/0, high: lanes 3/2
	logic [31:0]         rd_left;     // ram words still to send
	logic [SAMPLE_W-1:0] lo_calc;
	logic [SAMPLE_W-1:0] hi_calc;

	assign byte_ok = i_cmd_stb && !rd_wait && !rd_busy;

	// thresholds from centre and hysteresis, 12-bit wrap
	assign lo_calc = (({4'd0, frame_q.trig.centre} - {4'd0, frame_q.trig.hyst} - 12'd128) << 4)
	                 + 12'd8;
	assign hi_calc = (({4'd0, frame_q.trig.centre} + {4'd0, frame_q.trig.hyst} - 12'd128) << 4)
	                 + 12'd8;

	// --------------------
	// frame assembly
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt  <= '0;
			frame_vld <= 1'b0;
		end else begin
			frame_vld <= byte_ok && (byte_cnt == 3'd7);
			if (byte_ok)
				byte_cnt <= byte_cnt + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (byte_ok)
			frame_q.raw <= {i_cmd_byte, frame_q.raw[63:8]};
	end

	// --------------------
	// decode and readout sequencing
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_acq_cfg   <= '0;        // forced trigger, zero thresholds and length
			o_merge_cfg <= '0;
			preoffset   <= '0;
			o_arm_stb   <= 1'b0;
			rsp_stb_q   <= 1'b0;
			rsp_q       <= '0;
			rd_wait     <= 1'b0;
			rd_busy     <= 1'b0;
			rd_half     <= 1'b0;
			rd_left     <= '0;
			o_rd_addr   <= '0;
		end else begin
			o_arm_stb <= 1'b0;
			rsp_stb_q <= 1'b0;
			if (frame_vld) begin
				case (frame_q.rd.opcode)
					OP_ARM: begin
						o_acq_cfg.trig_type      <= frame_q.arm.trig_type;
						o_acq_cfg.length_to_take <= frame_q.arm.length_to_take;
						o_arm_stb <= 1'b1;
						rsp_stb_q <= 1'b1;
						rsp_q     <= {24'd0, i_status.state};   // state before arming
					end
					OP_INFO: begin
						rsp_stb_q <= 1'b1;
						case (frame_q.info.selector)
							8'd0:    rsp_q <= FW_VERSION;
							8'd1:    rsp_q <= i_status.event_count;
							default: rsp_q <= '0;
						endcase
					end
					OP_TRIG_SET: begin
						o_acq_cfg.lower_thresh <= sample_t'(lo_calc);
						o_acq_cfg.upper_thresh <= sample_t'(hi_calc);
						o_acq_cfg.tot          <= frame_q.trig.tot;
						preoffset <= {frame_q.trig.pre_hi[1:0], frame_q.trig.pre_lo};
						rsp_stb_q <= 1'b1;
						rsp_q     <= {24'd0, frame_q.trig.opcode};
					end
					OP_MERGE_SET: begin
						case (frame_q.merge.factor)
							8'd2:    o_merge_cfg.merge_sel <= MERGE_2;
							8'd4:    o_merge_cfg.merge_sel <= MERGE_4;
							default: o_merge_cfg.merge_sel <= MERGE_1;
						endcase
						o_merge_cfg.highres <= frame_q.merge.flags[0];
						rsp_stb_q <= 1'b1;
						rsp_q     <= {24'd0, frame_q.merge.opcode};
					end
					OP_READ: begin
						o_rd_addr <= i_status.trig_addr - preoffset;  // wraps around the ram
						rd_left   <= frame_q.rd.len;
						rd_wait   <= (frame_q.rd.len != 32'd0);
					end
					default: ;                                     // unknown, no answer
				endcase
			end
			if (rd_wait) begin
				rd_wait <= 1'b0;
				rd_busy <= 1'b1;
				rd_half <= 1'b0;
			end
			if (rd_busy) begin
				rd_half <= !rd_half;
				if (!rd_half) begin
					o_rd_addr <= o_rd_addr + 1'b1;     // next word ready after the second half
				end else begin
					rd_left <= rd_left - 32'd1;
					if (rd_left == 32'd1)
						rd_busy <= 1'b0;
				end
			end
		end
	end

	assign o_readout_done_stb = rd_busy & rd_half & (rd_left == 32'd1);
	assign o_rsp_stb  = rsp_stb_q | rd_busy;
	assign o_rsp_data = !rd_busy ? rsp_q :
	                    rd_half  ? {4'd0, i_rd_data[3], 4'd0, i_rd_data[2]} :
	                               {4'd0, i_rd_data[1], 4'd0, i_rd_data[0]};

endmodule

`default_nettype wire

// ==== rtl/capture_ram.sv ====
// circular capture memory
// wrapping write pointer, trigger address latch, registered read port
`timescale 1ns/1ps
`default_nettype none

module capture_ram #(
	parameter int DEPTH = scope_pkg::RAM_DEPTH
) (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_wr_stb,
	input  wire scope_pkg::sample_word_t i_wr_word,
	input  wire                          i_trig_mark,
	input  wire scope_pkg::addr_t        i_rd_addr,
	output scope_pkg::sample_word_t      o_rd_data,
	output scope_pkg::addr_t             o_trig_addr
);
	import scope_pkg::*;

	sample_word_t mem [DEPTH];
	addr_t        wr_ptr;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			o_trig_addr <= '0;
		end else if (i_wr_stb) begin
			wr_ptr <= (wr_ptr == addr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
			if (i_trig_mark)
				o_trig_addr <= wr_ptr;      // address of the trigger word
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr_stb)
			mem[wr_ptr] <= i_wr_word;
		o_rd_data <= mem[i_rd_addr];        // one cycle read latency
	end

endmodule

`default_nettype wire

// ==== rtl/trigger_ctrl.sv ====
// acquisition FSM with forced, rising and falling threshold triggers
// counts time over threshold and the post-trigger words
`timescale 1ns/1ps
`default_nettype none

module trigger_ctrl (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_merged_stb,
	input  wire scope_pkg::sample_word_t i_merged_word,
	input  wire scope_pkg::acq_cfg_t     i_acq_cfg,
	input  wire                          i_arm_stb,
	input  wire                          i_readout_done_stb,
	output logic                         o_wr_en,
	output logic                         o_trig_mark,
	output scope_pkg::acq_state_e        o_state,
	output logic [31:0]                  o_event_count
);
	import scope_pkg::*;

	logic        lo_hit;       // some lane below lower
	logic        hi_hit;       // some lane above upper
	logic        fire;
	logic        force_pend;   // forced trigger armed, waits for a word
	logic [7:0]  tot_cnt;      // words over threshold so far
	logic [15:0] post_cnt;

	always_comb begin
		lo_hit = 1'b0;
		hi_hit = 1'b0;
		for (int i = 0; i < LANES; i++) begin
			if ($signed(i_merged_word[i]) < $signed(i_acq_cfg.lower_thresh))
				lo_hit = 1'b1;
			if ($signed(i_merged_word[i]) > $signed(i_acq_cfg.upper_thresh))
				hi_hit = 1'b1;
		end
	end

	always_comb begin
		case (o_state)
			ACQ_IDLE:       fire = force_pend;
			ACQ_WAIT_HIGH:  fire = hi_hit && (tot_cnt == i_acq_cfg.tot);
			ACQ_WAIT_LOW_F: fire = lo_hit && (tot_cnt == i_acq_cfg.tot);
			default:        fire = 1'b0;
		endcase
	end

	assign o_trig_mark = i_merged_stb & fire;                     // ram latches this word
	assign o_wr_en     = i_merged_stb & (o_state != ACQ_DONE);    // keep pretrigger history

	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_state       <= ACQ_IDLE;
			force_pend    <= 1'b0;
			tot_cnt       <= '0;
			post_cnt      <= '0;
			o_event_count <= '0;
		end else begin
			case (o_state)
				ACQ_IDLE: begin
					tot_cnt  <= '0;
					post_cnt <= '0;
					if (o_trig_mark) begin
						force_pend <= 1'b0;
						o_state    <= ACQ_POST;
					end else if (i_arm_stb) begin
						case (i_acq_cfg.trig_type)
							TRIG_RISE: o_state <= ACQ_WAIT_LOW;
							TRIG_FALL: o_state <= ACQ_WAIT_HIGH_F;
							default:   force_pend <= 1'b1;   // fire on next word
						endcase
					end
				end
				ACQ_WAIT_LOW:
					if (i_merged_stb && lo_hit)
						o_state <= ACQ_WAIT_HIGH;
				ACQ_WAIT_HIGH:
					if (o_trig_mark)
						o_state <= ACQ_POST;
					else if (i_merged_stb && hi_hit)
						tot_cnt <= tot_cnt + 8'd1;
				ACQ_WAIT_HIGH_F:
					if (i_merged_stb && hi_hit)
						o_state <= ACQ_WAIT_LOW_F;
				ACQ_WAIT_LOW_F:
					if (o_trig_mark)
						o_state <= ACQ_POST;
					else if (i_merged_stb && lo_hit)
						tot_cnt <= tot_cnt + 8'd1;
				ACQ_POST:
					if (post_cnt == i_acq_cfg.length_to_take) begin
						o_state       <= ACQ_DONE;          // freeze the buffer
						o_event_count <= o_event_count + 32'd1;
					end else if (i_merged_stb) begin
						post_cnt <= post_cnt + 16'd1;
					end
				ACQ_DONE:
					if (i_readout_done_stb)
						o_state <= ACQ_IDLE;
				default:
					o_state <= ACQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sample_frontend.sv ====
// sample front end
// inverts adc lanes, then decimates or averages them into merged words
`timescale 1ns/1ps
`default_nettype none

module sample_frontend (
	input  wire                          clk,
	input  wire                          rstn,
	input  wire                          i_adc_stb,
	input  wire scope_pkg::sample_word_t i_adc_word,
	input  wire scope_pkg::merge_cfg_t   i_merge_cfg,
	output logic                         o_merged_stb,
	output scope_pkg::sample_word_t      o_merged_word
);
	import scope_pkg::*;

	sample_word_t               inv;       // negated lanes
	sample_word_t               res;       // group results, low lanes valid
	logic signed [SAMPLE_W+1:0] acc;       // group sum, room for four lanes
	logic [1:0]                 grp;       // input words already in this merged word
	logic [1:0]                 grp_last;
	logic [2:0]                 n_res;     // results per input word
	merge_cfg_t                 cfg_q;
	logic                       cfg_chg;

	assign grp_last = 2'((3'd1 << i_merge_cfg.merge_sel) - 3'd1);
	assign n_res    = 3'(LANES >> i_merge_cfg.merge_sel);
	assign cfg_chg  = (i_merge_cfg != cfg_q);

	// --------------------
	// invert and merge within one input word
	always_comb begin
		for (int i = 0; i < LANES; i++)
			inv[i] = (i_adc_word[i] == SAMPLE_MIN) ? SAMPLE_MAX : -i_adc_word[i];  // saturate
		res = inv;                                  // factor 1 passes every lane
		acc = '0;
		case (i_merge_cfg.merge_sel)
			MERGE_2: begin
				for (int j = 0; j < LANES / 2; j++) begin
					acc    = inv[2*j] + inv[2*j+1];
					res[j] = i_merge_cfg.highres ? sample_t'(acc >>> 1) : inv[2*j];
				end
			end
			MERGE_4: begin
				acc    = inv[0] + inv[1] + inv[2] + inv[3];
				res[0] = i_merge_cfg.highres ? sample_t'(acc >>> 2) : inv[0];
			end
			default: ;
		endcase
	end

	// --------------------
	// group counter, restarts on any config change
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			grp          <= '0;
			cfg_q        <= '0;
			o_merged_stb <= 1'b0;
		end else begin
			cfg_q        <= i_merge_cfg;
			o_merged_stb <= i_adc_stb && !cfg_chg && (grp == grp_last);  // word complete
			if (cfg_chg)
				grp <= '0;
			else if (i_adc_stb)
				grp <= (grp == grp_last) ? 2'd0 : grp + 2'd1;
		end
	end

	// assembly register, earliest group lands at lane 0
	always_ff @(posedge clk) begin
		if (i_adc_stb) begin
			for (int j = 0; j < LANES; j++)
				if (j < n_res)
					o_merged_word[grp*n_res + j] <= res[j];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/scope_pkg.sv ====
// scope acquisition core shared definitions
// widths, command and state codes, config structs and the command frame
`default_nettype none

package scope_pkg;

	localparam int SAMPLE_W   = 12;
	localparam int LANES      = 4;             // samples per word
	localparam int RAM_DEPTH  = 1024;          // capture words
	localparam int ADDR_W     = 10;
	localparam int RSP_W      = 32;
	localparam logic [RSP_W-1:0] FW_VERSION = 32'd19;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef sample_t [LANES-1:0]         sample_word_t;  // lane 0 is the earliest
	typedef logic [ADDR_W-1:0]           addr_t;

	localparam sample_t SAMPLE_MIN = sample_t'(-(2**(SAMPLE_W-1)));  // has no inverse
	localparam sample_t SAMPLE_MAX = sample_t'(2**(SAMPLE_W-1) - 1);

	typedef enum logic [7:0] {
		OP_READ      = 8'd0,
		OP_ARM       = 8'd1,
		OP_INFO      = 8'd2,
		OP_TRIG_SET  = 8'd8,
		OP_MERGE_SET = 8'd9
	} opcode_e;

	typedef enum logic [7:0] {
		TRIG_FORCE = 8'd0,
		TRIG_RISE  = 8'd1,
		TRIG_FALL  = 8'd2
	} trig_type_e;

	typedef enum logic [7:0] {
		ACQ_IDLE        = 8'd0,
		ACQ_WAIT_LOW    = 8'd1,    // rising, wait below lower
		ACQ_WAIT_HIGH   = 8'd2,    // rising, count above upper
		ACQ_WAIT_HIGH_F = 8'd3,    // falling, wait above upper
		ACQ_WAIT_LOW_F  = 8'd4,    // falling, count below lower
		ACQ_POST        = 8'd250,
		ACQ_DONE        = 8'd251
	} acq_state_e;

	// encoding equals log2 of the merge factor
	typedef enum logic [1:0] {
		MERGE_1 = 2'd0,
		MERGE_2 = 2'd1,
		MERGE_4 = 2'd2
	} merge_sel_e;

	// --------------------
	// configuration and status
	typedef struct packed {
		trig_type_e  trig_type;
		logic [15:0] length_to_take;   // words written after the trigger
		sample_t     lower_thresh;
		sample_t     upper_thresh;
		logic [7:0]  tot;              // extra words over threshold
	} acq_cfg_t;

	typedef struct packed {
		merge_sel_e merge_sel;
		logic       highres;           // average instead of decimate
	} merge_cfg_t;

	typedef struct packed {
		acq_state_e  state;
		addr_t       trig_addr;
		logic [31:0] event_count;
	} acq_status_t;

	// --------------------
	// command frame views, byte 7 at the top and byte 0 the opcode
	typedef struct packed {
		logic [31:0] len;              // words, little endian
		logic [23:0] rsvd;
		opcode_e     opcode;
	} read_cmd_t;

	typedef struct packed {
		logic [15:0] rsvd_hi;
		logic [15:0] length_to_take;   // bytes 5..4
		logic [15:0] rsvd_lo;
		trig_type_e  trig_type;
		opcode_e     opcode;
	} arm_cmd_t;

	typedef struct packed {
		logic [47:0] rsvd;
		logic [7:0]  selector;
		opcode_e     opcode;
	} info_cmd_t;

	typedef struct packed {
		logic [15:0] rsvd;
		logic [7:0]  tot;
		logic [7:0]  pre_lo;           // preoffset low byte
		logic [7:0]  pre_hi;           // only bits 1..0 used
		logic [7:0]  hyst;
		logic [7:0]  centre;
		opcode_e     opcode;
	} trig_cmd_t;

	typedef struct packed {
		logic [31:0] rsvd_hi;
		logic [7:0]  factor;           // 1, 2 or 4
		logic [7:0]  flags;            // bit 0 highres
		logic [7:0]  rsvd_lo;
		opcode_e     opcode;
	} merge_cmd_t;

	typedef union packed {
		logic [63:0] raw;
		read_cmd_t   rd;
		arm_cmd_t    arm;
		info_cmd_t   info;
		trig_cmd_t   trig;
		merge_cmd_t  merge;
	} cmd_frame_u;

endpackage

`default_nettype wire
